/* src/rvAluPipe_defines.svh */
`ifndef RV_ALU_PIPE_DEFINES_SVH
`define RV_ALU_PIPE_DEFINES_SVH

// Datapath word width.
`define XLEN 32

// Register index width, 32 architectural registers.
`define REG_ADDR_W 5

`define TRIGGER_REG 5   // t0, preset to 1 by the trigger input.
`define EXPORT_REG 10   // a0, shown on the top-level a0 port.

`endif

/* src/rvAluPipePkg.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

package rvAluPipePkg;

    typedef enum logic [3:0] {
        aluAdd,                                 // Also addi.
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpE;

    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate.

    typedef struct packed {
        logic [`XLEN-1:0]       opA;            // Forwarded rs1 value.
        logic [`XLEN-1:0]       opB;            // Forwarded rs2 value.
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   useImm;         // Operand B from imm.
        logic [`XLEN-1:0]       imm;
        aluOpE                  aluOp;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   illegal;
    } deStageT;

    typedef struct packed {
        logic [`XLEN-1:0]       result;
        logic [`REG_ADDR_W-1:0] rd;             // Zero for illegal words.
        logic                   illegal;
    } ewStageT;

endpackage

`default_nettype wire

/* src/instrDecoder.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]       instr,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`XLEN-1:0]       imm,
    output logic                   useImm,
    output rvAluPipePkg::aluOpE    aluOp,
    output logic                   illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isShift;                        // slli, srli, srai and the OP shifts.
    logic       altForm;                        // funct7 picks sub or sra.
    logic       funct7Ok;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign isShift  = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign altForm  = (funct7 == 7'b0100000) &&
                      ((funct3 == 3'b101) || (funct3 == 3'b000 && opcode == rvAluPipePkg::OPC_OP));
    assign funct7Ok = (funct7 == 7'b0000000) || altForm;

    always_comb begin
        rs1     = instr[19:15];
        rs2     = '0;                            // Only OP reads a second register.
        rd      = instr[11:7];
        imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]}; // Sign-extended I-immediate.
        useImm  = 1'b0;
        illegal = 1'b0;

        case (funct3)
            3'b000:  aluOp = altForm ? rvAluPipePkg::aluSub : rvAluPipePkg::aluAdd;
            3'b001:  aluOp = rvAluPipePkg::aluSll;
            3'b010:  aluOp = rvAluPipePkg::aluSlt;
            3'b011:  aluOp = rvAluPipePkg::aluSltu;
            3'b100:  aluOp = rvAluPipePkg::aluXor;
            3'b101:  aluOp = altForm ? rvAluPipePkg::aluSra : rvAluPipePkg::aluSrl;
            3'b110:  aluOp = rvAluPipePkg::aluOr;
            default: aluOp = rvAluPipePkg::aluAnd;
        endcase

        if (opcode == rvAluPipePkg::OPC_OP) begin
            rs2     = instr[24:20];
            illegal = !funct7Ok;                 // Only 0000000, or 0100000 on sub and sra.
        end else if (opcode == rvAluPipePkg::OPC_OP_IMM) begin
            useImm = 1'b1;
            if (isShift) begin
                imm     = {{(`XLEN-5){1'b0}}, instr[24:20]}; // 5-bit shift amount.
                illegal = !funct7Ok;
            end
        end else begin
            illegal = 1'b1;                      // Opcode outside the supported set.
        end

        if (illegal) begin
            rd = '0;                             // Illegal words write nothing.
        end
    end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   writeEn,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData,
    input  logic [`REG_ADDR_W-1:0] readAddr1,
    input  logic [`REG_ADDR_W-1:0] readAddr2,
    input  logic                   trigger,
    output logic [`XLEN-1:0]       readData1,
    output logic [`XLEN-1:0]       readData2,
    output logic [`XLEN-1:0]       a0
);

    logic [`XLEN-1:0] regs [1:(2**`REG_ADDR_W)-1]; // x0 has no storage.

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (writeEn && writeAddr != '0) begin
                regs[writeAddr] <= writeData;
            end
            if (trigger) begin
                regs[`TRIGGER_REG] <= `XLEN'(1);  // Later assignment wins over the write.
            end
        end
    end

    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1]; // x0 hard-wired.
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
    assign a0        = regs[`EXPORT_REG];          // Continuous a0 tap.

    // Reads of x0 return zero on both ports.
    assert property (@(posedge clk) disable iff (!arstN)
        (readAddr1 == '0 |-> readData1 == '0) and (readAddr2 == '0 |-> readData2 == '0))
        else $error("x0 read returned nonzero data");

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

module aluUnit (
    input  logic [`XLEN-1:0]    opA,
    input  logic [`XLEN-1:0]    opB,
    input  rvAluPipePkg::aluOpE aluOp,
    output logic [`XLEN-1:0]    result
);

    logic [4:0] shamt;                           // RV32I uses 5 bits of B.
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            rvAluPipePkg::aluAdd:  result = opA + opB;
            rvAluPipePkg::aluSub:  result = opA - opB;
            rvAluPipePkg::aluSll:  result = opA << shamt;
            rvAluPipePkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, ltSigned};
            rvAluPipePkg::aluSltu: result = {{(`XLEN-1){1'b0}}, ltUnsigned};
            rvAluPipePkg::aluXor:  result = opA ^ opB;
            rvAluPipePkg::aluSrl:  result = opA >> shamt;
            rvAluPipePkg::aluSra:  result = $unsigned($signed(opA) >>> shamt); // Sign fill.
            rvAluPipePkg::aluOr:   result = opA | opB;
            rvAluPipePkg::aluAnd:  result = opA & opB;
            default:               result = '0;  // Unused enum codes.
        endcase
    end

endmodule

`default_nettype wire

/* src/pipeReg.sv */
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    assign inReady = !outValid || outReady;      // Empty, or draining this edge.

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;                  // Refill or go empty.
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;                    // Load only on a transfer in.
        end
    end

    // A stalled entry keeps its content until it moves on.
    assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("Pipeline payload changed while stalled");

endmodule

`default_nettype wire

/* src/rvAluPipe.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

module rvAluPipe (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`XLEN-1:0]       instr,
    input  logic                   instrValid,
    output logic                   instrReady,
    input  logic                   trigger,
    output logic                   retireValid,
    input  logic                   retireReady,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic                   retireIllegal,
    output logic [`XLEN-1:0]       a0
);

    logic [`REG_ADDR_W-1:0] decRs1;
    logic [`REG_ADDR_W-1:0] decRs2;
    logic [`REG_ADDR_W-1:0] decRd;
    logic [`XLEN-1:0]       decImm;
    logic                   decUseImm;
    rvAluPipePkg::aluOpE    decAluOp;
    logic                   decIllegal;
    logic [`XLEN-1:0]       rfData1;
    logic [`XLEN-1:0]       rfData2;

    rvAluPipePkg::deStageT  deIn;
    rvAluPipePkg::deStageT  deOut;
    logic                   deValid;
    rvAluPipePkg::ewStageT  ewIn;
    rvAluPipePkg::ewStageT  ewOut;
    logic                   ewValid;
    logic                   ewReady;

    logic [`XLEN-1:0]       aluB;
    logic [`XLEN-1:0]       aluResult;
    logic                   exFwdOk;                     // Execute holds a writing instruction.
    logic                   wbFwdOk;                     // Writeback holds a writing instruction.

    function automatic logic [`XLEN-1:0] pickOperand(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`XLEN-1:0]       rfVal,
        input logic                   exOk,
        input logic [`REG_ADDR_W-1:0] exRd,
        input logic [`XLEN-1:0]       exVal,
        input logic                   wbOk,
        input logic [`REG_ADDR_W-1:0] wbRd,
        input logic [`XLEN-1:0]       wbVal
    );
        if (src == '0) return rfVal;                     // x0 never forwarded.
        if (exOk && exRd == src) return exVal;           // Youngest producer first.
        if (wbOk && wbRd == src) return wbVal;
        return rfVal;
    endfunction

    instrDecoder instrDecoder_inst (
        .instr(instr), .rs1(decRs1), .rs2(decRs2), .rd(decRd), .imm(decImm),
        .useImm(decUseImm), .aluOp(decAluOp), .illegal(decIllegal)
    );

    registerFile registerFile_inst (
        .clk(clk), .arstN(arstN),
        .writeEn(ewValid && retireReady && !ewOut.illegal), // Write on retire transfer.
        .writeAddr(ewOut.rd), .writeData(ewOut.result),
        .readAddr1(decRs1), .readAddr2(decRs2), .trigger(trigger),
        .readData1(rfData1), .readData2(rfData2), .a0(a0)
    );

    assign exFwdOk = deValid && !deOut.illegal && deOut.rd != '0;
    assign wbFwdOk = ewValid && !ewOut.illegal && ewOut.rd != '0;

    always_comb begin
        deIn.opA     = pickOperand(decRs1, rfData1, exFwdOk, deOut.rd, aluResult,
                                   wbFwdOk, ewOut.rd, ewOut.result);
        deIn.opB     = pickOperand(decRs2, rfData2, exFwdOk, deOut.rd, aluResult,
                                   wbFwdOk, ewOut.rd, ewOut.result);
        deIn.rs1     = decRs1;
        deIn.rs2     = decRs2;
        deIn.useImm  = decUseImm;
        deIn.imm     = decImm;
        deIn.aluOp   = decAluOp;
        deIn.rd      = decRd;
        deIn.illegal = decIllegal;
    end

    pipeReg #(.payloadT(rvAluPipePkg::deStageT)) deStage_inst (
        .clk(clk), .arstN(arstN), .inValid(instrValid), .inData(deIn), .inReady(instrReady),
        .outValid(deValid), .outData(deOut), .outReady(ewReady)
    );

    assign aluB = deOut.useImm ? deOut.imm : deOut.opB; // Immediate or register.

    aluUnit aluUnit_inst (.opA(deOut.opA), .opB(aluB), .aluOp(deOut.aluOp), .result(aluResult));

    assign ewIn.result  = deOut.illegal ? '0 : aluResult; // Illegal words retire zero.
    assign ewIn.rd      = deOut.rd;
    assign ewIn.illegal = deOut.illegal;

    pipeReg #(.payloadT(rvAluPipePkg::ewStageT)) ewStage_inst (
        .clk(clk), .arstN(arstN), .inValid(deValid), .inData(ewIn), .inReady(ewReady),
        .outValid(ewValid), .outData(ewOut), .outReady(retireReady)
    );

    assign retireValid   = ewValid;
    assign retireRd      = ewOut.rd;
    assign retireData    = ewOut.result;
    assign retireIllegal = ewOut.illegal;

    // Forwarded operands of x0 sources stay zero through execute.
    assert property (@(posedge clk) disable iff (!arstN)
        deValid |-> (deOut.rs1 != '0 || deOut.opA == '0) && (deOut.rs2 != '0 || deOut.opB == '0))
        else $error("Nonzero operand for an x0 source");

endmodule

`default_nettype wire

/* tb/rvAluPipeTb.sv */
`default_nettype none

`include "rvAluPipe_defines.svh"

module rvAluPipeTb;

    localparam int TOTAL_INSTRS = 1152;                  // Batch sizes plus the single words.
    localparam int CYCLE_LIMIT  = 4 * TOTAL_INSTRS + 200;
    localparam logic [4:0] HOT_REGS [8] = '{0, 1, 2, 3, 5, 6, 10, 11}; // Hazard-heavy set.

    logic clk = 1'b0;
    logic arstN = 1'b0;
    logic [`XLEN-1:0] instr = '0;
    logic instrValid = 1'b0;
    logic trigger = 1'b0;
    logic retireReady = 1'b0;
    logic instrReady, retireValid, retireIllegal;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0] retireData, a0;

    logic [31:0] lfsr = 32'h62a1a07f;
    logic [31:0] model [32];                             // Architectural register state.
    logic [31:0] pendWord [$];                           // Accepted, not yet retired.
    int pendCycle [$];
    int cycle = 0, errors = 0, checks = 0, retired = 0, numTests = 0;
    int errorsAtStart, retiredAtStart, acceptCycle;
    string testName = "reset";
    logic inTaken = 1'b0, heldValid = 1'b0, checkLatency = 1'b0;
    logic [63:0] heldPay, curPay;
    logic [4:0] expRd;
    logic [31:0] expData, lastData;
    logic expIll;

    rvAluPipe rvAluPipe_inst (
        .clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
        .instrReady(instrReady), .trigger(trigger), .retireValid(retireValid),
        .retireReady(retireReady), .retireRd(retireRd), .retireData(retireData),
        .retireIllegal(retireIllegal), .a0(a0)
    );

    always #4 clk = ~clk;                                // Period 8.

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32, 22, 2, 1.
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] pickReg();
        return HOT_REGS[3'(randBits(3))];
    endfunction

    // Mode 0 mixed, 1 OP-IMM only, 2 many illegal words and rd x0, 3 many writes to a0.
    function automatic logic [31:0] genInstr(input int mode);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm12;
        logic [4:0] rs1, rs2, rd;
        f3    = 3'(randBits(3));
        imm12 = 12'(randBits(12));
        rs1   = pickReg();
        rs2   = pickReg();
        rd    = pickReg();
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && randBits(1) != 0) ? 7'b0100000 : 7'b0000000;
        if (mode == 2 && randBits(1) != 0) rd = '0;
        if (mode == 3 && randBits(1) != 0) rd = 5'd10;
        if (randBits(4) == 0 || (mode == 2 && randBits(2) == 0)) return randBits(32);
        if (mode == 1 || randBits(1) != 0) begin
            if (f3 == 3'd1 || f3 == 3'd5) imm12[11:5] = f7; // Shift-immediate form.
            return {imm12, rs1, f3, rd, rvAluPipePkg::OPC_OP_IMM};
        end
        return {f7, rs2, rs1, f3, rd, rvAluPipePkg::OPC_OP};
    endfunction

    // RV32I OP and OP-IMM semantics, evaluated on the in-order model state.
    function automatic void modelExec(input logic [31:0] w, output logic [4:0] rd,
                                      output logic [31:0] data, output logic ill);
        logic [2:0] f3;
        logic [31:0] a, b;
        logic isOp, isImm, isShift, alt;
        f3      = w[14:12];
        isOp    = w[6:0] == 7'b0110011;
        isImm   = w[6:0] == 7'b0010011;
        isShift = f3 == 3'd1 || f3 == 3'd5;
        alt     = w[31:25] == 7'b0100000;
        a       = model[w[19:15]];
        b       = isOp ? model[w[24:20]] :
                  isShift ? {27'd0, w[24:20]} : {{20{w[31]}}, w[31:20]};
        ill     = !(isOp || isImm) || ((isOp || isShift) &&
                  !(w[31:25] == 7'd0 || (alt && (f3 == 3'd5 || (f3 == 3'd0 && isOp)))));
        case (f3)
            3'd0:    data = (isOp && alt) ? a - b : a + b;
            3'd1:    data = a << b[4:0];
            3'd2:    data = {31'd0, $signed(a) < $signed(b)};
            3'd3:    data = {31'd0, a < b};
            3'd4:    data = a ^ b;
            3'd5: begin
                if (alt) begin
                    data = $signed(a) >>> b[4:0];        // Sign fill for sra and srai.
                end else begin
                    data = a >> b[4:0];
                end
            end
            3'd6:    data = a | b;
            default: data = a & b;
        endcase
        rd = ill ? 5'd0 : w[11:7];                       // Illegal words target nothing.
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        checks++;
        assert (actVal == expVal) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", testName, what, expVal, actVal);
            errors++;
        end
    endtask

    // Sampled at the falling edge, where every handshake signal is settled.
    always @(negedge clk) begin
        if (arstN) begin
            if (trigger) model[`TRIGGER_REG] = 32'd1;
            checkValue("a0", model[`EXPORT_REG], a0);        // Model holds only landed writes.
            curPay = {25'd0, retireValid, retireIllegal, retireRd, retireData};
            if (heldValid) checkValue("stalled payload", heldPay, curPay);
            assert (instrReady || !retireReady) else begin
                $display("instrReady fell in %s while retire was ready", testName);
                errors++;
            end
            if (retireValid && retireReady) begin
                assert (pendWord.size() != 0) else begin
                    $display("Retirement in %s with no instruction pending", testName);
                    errors++;
                end
                if (pendWord.size() != 0) begin
                    modelExec(pendWord.pop_front(), expRd, expData, expIll);
                    acceptCycle = pendCycle.pop_front();
                    checkValue("rd", expRd, retireRd);
                    checkValue("illegal", expIll, retireIllegal);
                    if (!expIll) begin
                        checkValue("data", expData, retireData);
                        if (expRd != 5'd0) model[expRd] = expData; // x0 stays zero.
                    end
                    if (checkLatency) checkValue("latency", 2, cycle - acceptCycle);
                    lastData = retireData;
                    retired++;
                end
            end
            heldPay   = curPay;
            heldValid = retireValid && !retireReady;
            inTaken   = instrValid && instrReady;            // Transfers at the next edge.
            if (inTaken) begin
                pendWord.push_back(instr);
                pendCycle.push_back(cycle);
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles in %s, the pipeline stalled", cycle, testName);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic runBatch(input int count, input int mode, input bit stall);
        int issued;
        issued = 0;
        forever begin
            @(posedge clk);
            retireReady <= stall ? randBits(1) != 0 : 1'b1;
            if (!instrValid || inTaken) begin            // Word held until taken.
                if (issued == count) begin
                    instrValid <= 1'b0;
                    break;
                end
                if (stall && randBits(2) == 0) begin
                    instrValid <= 1'b0;                  // Input gap.
                end else begin
                    instr      <= genInstr(mode);
                    instrValid <= 1'b1;
                    issued++;
                end
            end
        end
    endtask

    task automatic sendWord(input logic [31:0] w);
        @(posedge clk);
        instr       <= w;
        instrValid  <= 1'b1;
        retireReady <= 1'b1;
        do @(posedge clk); while (!inTaken);
        instrValid <= 1'b0;
    endtask

    task automatic drainPipe();
        @(posedge clk);
        retireReady <= 1'b1;
        instrValid  <= 1'b0;
        while (pendWord.size() != 0) @(posedge clk);
        @(posedge clk);                                  // Last write lands.
    endtask

    task automatic startTest(input string name);
        testName       = name;
        errorsAtStart  = errors;
        retiredAtStart = retired;
    endtask

    task automatic reportTest();
        numTests++;
        $display("Test %s finished: %0d retired, %0d errors", testName,
                 retired - retiredAtStart, errors - errorsAtStart);
    endtask

    initial begin
        for (int i = 0; i < 32; i++) model[i] = '0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        assert (instrReady && !retireValid && a0 == '0) else begin
            $display("Reset state wrong: instrReady %b retireValid %b", instrReady, retireValid);
            errors++;
        end
        startTest("dependent");
        checkLatency = 1'b1;
        runBatch(400, 0, 1'b0);
        drainPipe();
        checkLatency = 1'b0;
        reportTest();
        startTest("immediates");
        runBatch(200, 1, 1'b0);
        drainPipe();
        reportTest();
        startTest("backpressure");
        runBatch(300, 0, 1'b1);
        drainPipe();
        reportTest();
        startTest("illegal_x0");
        runBatch(150, 2, 1'b0);
        drainPipe();
        reportTest();
        startTest("trigger");
        sendWord({12'd7, 5'd0, 3'd0, 5'd5, rvAluPipePkg::OPC_OP_IMM}); // addi x5, x0, 7.
        drainPipe();
        @(posedge clk);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
        sendWord({12'd0, 5'd5, 3'd0, 5'd6, rvAluPipePkg::OPC_OP_IMM}); // addi x6, x5, 0.
        drainPipe();
        checkValue("x5 after trigger", 32'd1, lastData);
        reportTest();
        startTest("a0_export");
        runBatch(100, 3, 1'b0);
        drainPipe();
        checkValue("a0 final", model[`EXPORT_REG], a0);
        checkValue("retired count", TOTAL_INSTRS, retired);
        reportTest();
        $display("Tests %0d, checks %0d, retired %0d, errors %0d",
                 numTests, checks, retired, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rvAluPipe.f */
+incdir+src
src/rvAluPipePkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/aluUnit.sv
src/pipeReg.sv
src/rvAluPipe.sv
tb/rvAluPipeTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f rvAluPipe.f \
    --top-module rvAluPipeTb -o rvAluPipeSim
./obj_dir/rvAluPipeSim > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
exit 1
